//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 --top-module tb_dma_wrap -f flist.f
	./obj_dir/Vtb_dma_wrap > sim.log 2>&1 || true
	cat sim.log
	@! grep -q "Simulation failed" sim.log
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dma_addr_router.sv
// DMA address router
// sends each engine access to the TCDM or the SoC port by address window,
// returns the reply from the port that took the request
`timescale 1ns/1ps
`default_nettype none

module dma_addr_router #(
  parameter logic [dma_pkg::addr_w-1:0] TCDM_BASE = 32'h1000_0000,
  parameter logic [dma_pkg::addr_w-1:0] TCDM_SIZE = 32'h0010_0000
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  dma_pkg::mem_req_t dma_req_i,
  output dma_pkg::mem_rsp_t dma_rsp_o,
  output dma_pkg::mem_req_t tcdm_req_o,
  input  dma_pkg::mem_rsp_t tcdm_rsp_i,
  output dma_pkg::mem_req_t ext_req_o,
  input  dma_pkg::mem_rsp_t ext_rsp_i
);
  import dma_pkg::*;

  logic [addr_w-1:0] win_offset;
  logic              in_tcdm;
  logic              sel_tcdm_q;

  // unsigned offset also rejects addresses below the base
  assign win_offset = dma_req_i.addr - TCDM_BASE;
  assign in_tcdm    = win_offset < TCDM_SIZE;

  always_comb begin
    tcdm_req_o       = dma_req_i;
    ext_req_o        = dma_req_i;
    tcdm_req_o.valid = dma_req_i.valid & in_tcdm;
    ext_req_o.valid  = dma_req_i.valid & ~in_tcdm;
  end

  // remember the target for the reply one cycle later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_tcdm_q <= 1'b0;
    end else if (dma_req_i.valid) begin
      sel_tcdm_q <= in_tcdm;
    end
  end

  assign dma_rsp_o = sel_tcdm_q ? tcdm_rsp_i : ext_rsp_i;

endmodule

`default_nettype wire

//--- dma_ctrl_regs.sv
// DMA control register file
// descriptor registers, command decode into a start strobe,
// termination event and sticky interrupt with software clear
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_regs (
  input  logic                clk_i,
  input  logic                reset_i,
  input  dma_pkg::cfg_req_t   cfg_req_i,
  output dma_pkg::cfg_rsp_t   cfg_rsp_o,
  input  logic                busy_i,
  input  logic                done_i,
  output logic                start_o,
  output dma_pkg::xfer_desc_t desc_o,
  output logic                term_event_o,
  output logic                term_irq_o
);
  import dma_pkg::*;

  xfer_desc_t        desc_q;
  logic              irq_en_q;
  logic              irq_pend_q;
  logic              rsp_valid_q;
  logic [data_w-1:0] rsp_rdata_q;
  logic [data_w-1:0] rd_data;
  logic              wr_en;
  logic              clr_irq;
  dma_cmd_u          cmd_wr;
  dma_cmd_u          cmd_rd;

  assign wr_en  = cfg_req_i.valid & cfg_req_i.write;
  assign cmd_wr = cfg_req_i.wdata;

  // only an idle engine accepts a new command
  assign start_o = wr_en & (cfg_req_i.reg_addr == reg_cmd) &
                   cmd_wr.fields.start & ~busy_i;

  assign clr_irq = wr_en & (cfg_req_i.reg_addr == reg_status) & cfg_req_i.wdata[1];

  // command readback shows the stored irq enable, start reads as zero
  always_comb begin
    cmd_rd.raw           = '0;
    cmd_rd.fields.irq_en = irq_en_q;
  end

  always_comb begin
    rd_data = '0;
    case (cfg_req_i.reg_addr)
      reg_src:    rd_data = desc_q.src;
      reg_dst:    rd_data = desc_q.dst;
      reg_len:    rd_data = desc_q.len;
      reg_cmd:    rd_data = cmd_rd.raw;
      reg_status: rd_data = {{(data_w-2){1'b0}}, irq_pend_q, busy_i};
      default:    rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      desc_q      <= '0;
      irq_en_q    <= 1'b0;
      irq_pend_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= cfg_req_i.valid;
      // descriptor is frozen while a transfer runs
      if (wr_en && !busy_i) begin
        case (cfg_req_i.reg_addr)
          reg_src: desc_q.src <= cfg_req_i.wdata;
          reg_dst: desc_q.dst <= cfg_req_i.wdata;
          reg_len: desc_q.len <= cfg_req_i.wdata;
          default: ;
        endcase
      end
      if (start_o) begin
        irq_en_q <= cmd_wr.fields.irq_en;
      end
      // a new completion wins over a clear in the same cycle
      if (clr_irq) begin
        irq_pend_q <= 1'b0;
      end
      if (done_i && irq_en_q) begin
        irq_pend_q <= 1'b1;
      end
    end
  end

  // reply data, zero for writes
  always_ff @(posedge clk_i) begin
    if (cfg_req_i.valid) begin
      rsp_rdata_q <= cfg_req_i.write ? '0 : rd_data;
    end
  end

  assign cfg_rsp_o = '{valid: rsp_valid_q, rdata: rsp_rdata_q};

  assign desc_o       = desc_q;
  assign term_event_o = done_i;
  assign term_irq_o   = irq_pend_q;

endmodule

`default_nettype wire

//--- dma_pkg.sv
// cluster DMA shared definitions
// widths, register map, bus structs and the command word layout
`default_nettype none

package dma_pkg;

  localparam int unsigned data_w      = 32;
  localparam int unsigned addr_w      = 32;
  // bank word address drops the byte offset and the bank select bit
  localparam int unsigned bank_addr_w = addr_w - 3;

  typedef logic [3:0] reg_addr_t;

  // register map, word indexed
  localparam reg_addr_t reg_src    = 4'h0;
  localparam reg_addr_t reg_dst    = 4'h1;
  localparam reg_addr_t reg_len    = 4'h2;
  localparam reg_addr_t reg_cmd    = 4'h3;
  localparam reg_addr_t reg_status = 4'h4;

  typedef struct packed {
    logic              valid;
    logic              write;
    reg_addr_t         reg_addr;
    logic [data_w-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic              valid;
    logic [data_w-1:0] rdata;
  } cfg_rsp_t;

  typedef struct packed {
    logic              valid;
    logic              we;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic [data_w-1:0] rdata;
  } mem_rsp_t;

  // bank side, write enable is active low
  typedef struct packed {
    logic                   req;
    logic                   wen_n;
    logic [bank_addr_w-1:0] addr;
    logic [data_w-1:0]      wdata;
  } bank_req_t;

  typedef struct packed {
    logic [addr_w-1:0] src;
    logic [addr_w-1:0] dst;
    logic [data_w-1:0] len;
  } xfer_desc_t;

  typedef struct packed {
    logic [29:0] reserved;
    logic        irq_en;
    logic        start;
  } dma_cmd_fields_t;

  // command register seen as a raw word or as fields
  typedef union packed {
    logic [data_w-1:0] raw;
    dma_cmd_fields_t   fields;
  } dma_cmd_u;

endpackage

`default_nettype wire

//--- dma_transfer_engine.sv
// DMA transfer engine
// copies 32-bit words from source to destination one at a time,
// read, wait for data, write, three cycles per word
`timescale 1ns/1ps
`default_nettype none

module dma_transfer_engine (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                start_i,
  input  dma_pkg::xfer_desc_t desc_i,
  output logic                busy_o,
  output logic                done_o,
  output dma_pkg::mem_req_t   mem_req_o,
  input  dma_pkg::mem_rsp_t   mem_rsp_i
);
  import dma_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_wait,
    st_write
  } state_e;

  localparam logic [addr_w-1:0] word_step = 4;

  state_e            state_q;
  logic [addr_w-1:0] src_q;
  logic [addr_w-1:0] dst_q;
  logic [data_w-1:0] cnt_q;
  logic [data_w-1:0] data_q;
  logic              done_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= st_idle;
      src_q   <= '0;
      dst_q   <= '0;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (start_i) begin
            src_q <= desc_i.src;
            dst_q <= desc_i.dst;
            cnt_q <= desc_i.len;
            // empty transfer finishes right away
            if (desc_i.len == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= st_read;
            end
          end
        end
        st_read: begin
          state_q <= st_wait;
        end
        st_wait: begin
          if (mem_rsp_i.valid) begin
            state_q <= st_write;
          end
        end
        st_write: begin
          src_q <= src_q + word_step;
          dst_q <= dst_q + word_step;
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == data_w'(1)) begin
            done_q  <= 1'b1;
            state_q <= st_idle;
          end else begin
            state_q <= st_read;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // read data held for the write cycle
  always_ff @(posedge clk_i) begin
    if (state_q == st_wait && mem_rsp_i.valid) begin
      data_q <= mem_rsp_i.rdata;
    end
  end

  always_comb begin
    mem_req_o = '0;
    case (state_q)
      st_read: begin
        mem_req_o.valid = 1'b1;
        mem_req_o.we    = 1'b0;
        mem_req_o.addr  = src_q;
      end
      st_write: begin
        mem_req_o.valid = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = dst_q;
        mem_req_o.wdata = data_q;
      end
      default: mem_req_o = '0;
    endcase
  end

  // busy also covers the done cycle
  assign busy_o = (state_q != st_idle) | done_q;
  assign done_o = done_q;

endmodule

`default_nettype wire

//--- dma_wrap.sv
// cluster DMA top level
// register file, transfer engine, address router and TCDM bank demux
`timescale 1ns/1ps
`default_nettype none

module dma_wrap #(
  parameter logic [dma_pkg::addr_w-1:0] TCDM_BASE = 32'h1000_0000,
  parameter logic [dma_pkg::addr_w-1:0] TCDM_SIZE = 32'h0010_0000
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  dma_pkg::cfg_req_t               cfg_req_i,
  output dma_pkg::cfg_rsp_t               cfg_rsp_o,
  output dma_pkg::mem_req_t               ext_req_o,
  input  dma_pkg::mem_rsp_t               ext_rsp_i,
  output dma_pkg::bank_req_t [1:0]        bank_req_o,
  input  logic [1:0]                      bank_rvalid_i,
  input  logic [1:0][dma_pkg::data_w-1:0] bank_rdata_i,
  output logic                            term_event_o,
  output logic                            term_irq_o,
  output logic                            busy_o
);
  import dma_pkg::*;

  logic       start;
  logic       done;
  xfer_desc_t desc;
  mem_req_t   dma_req;
  mem_rsp_t   dma_rsp;
  mem_req_t   tcdm_req;
  mem_rsp_t   tcdm_rsp;

  dma_ctrl_regs i_ctrl_regs (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .cfg_req_i    ( cfg_req_i    ),
    .cfg_rsp_o    ( cfg_rsp_o    ),
    .busy_i       ( busy_o       ),
    .done_i       ( done         ),
    .start_o      ( start        ),
    .desc_o       ( desc         ),
    .term_event_o ( term_event_o ),
    .term_irq_o   ( term_irq_o   )
  );

  dma_transfer_engine i_engine (
    .clk_i     ( clk_i   ),
    .reset_i   ( reset_i ),
    .start_i   ( start   ),
    .desc_i    ( desc    ),
    .busy_o    ( busy_o  ),
    .done_o    ( done    ),
    .mem_req_o ( dma_req ),
    .mem_rsp_i ( dma_rsp )
  );

  dma_addr_router #(
    .TCDM_BASE ( TCDM_BASE ),
    .TCDM_SIZE ( TCDM_SIZE )
  ) i_router (
    .clk_i      ( clk_i     ),
    .reset_i    ( reset_i   ),
    .dma_req_i  ( dma_req   ),
    .dma_rsp_o  ( dma_rsp   ),
    .tcdm_req_o ( tcdm_req  ),
    .tcdm_rsp_i ( tcdm_rsp  ),
    .ext_req_o  ( ext_req_o ),
    .ext_rsp_i  ( ext_rsp_i )
  );

  tcdm_bank_demux i_bank_demux (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .req_i         ( tcdm_req      ),
    .rsp_o         ( tcdm_rsp      ),
    .bank_req_o    ( bank_req_o    ),
    .bank_rvalid_i ( bank_rvalid_i ),
    .bank_rdata_i  ( bank_rdata_i  )
  );

endmodule

`default_nettype wire

//--- flist.f
dma_pkg.sv
dma_ctrl_regs.sv
dma_transfer_engine.sv
dma_addr_router.sv
tcdm_bank_demux.sv
dma_wrap.sv
tb_dma_wrap.sv

//--- tb_dma_wrap.sv
// testbench for the cluster DMA top level
// two TCDM bank models and an SoC memory model, a table of transfers
// checked against a reference copy of the memory image
`timescale 1ns/1ps
`default_nettype none

module tb_dma_wrap;
  import dma_pkg::*;

  localparam logic [addr_w-1:0] tcdm_base = 32'h1000_0000;
  localparam logic [addr_w-1:0] tcdm_size = 32'h0010_0000;
  localparam logic [addr_w-1:0] ext_base  = 32'h2000_0000;
  localparam int                n_tests   = 4;
  localparam int                tmo       = 200;

  logic                   clk = 1'b0;
  logic                   reset;
  cfg_req_t               cfg_req;
  cfg_rsp_t               cfg_rsp;
  mem_req_t               ext_req;
  mem_rsp_t               ext_rsp;
  bank_req_t [1:0]        bank_req;
  logic [1:0]             bank_rvalid;
  logic [1:0][data_w-1:0] bank_rdata;
  logic                   term_event;
  logic                   term_irq;
  logic                   busy;

  // transfer table: name, source, destination, word count, irq enable
  string             t_name [n_tests] = '{"tcdm_to_tcdm", "ext_to_tcdm", "tcdm_to_ext",
                                          "zero_len"};
  logic [addr_w-1:0] t_src  [n_tests] = '{tcdm_base + 32'h004, ext_base + 32'h010,
                                          tcdm_base + 32'h020, tcdm_base + 32'h100};
  logic [addr_w-1:0] t_dst  [n_tests] = '{tcdm_base + 32'h080, tcdm_base + 32'h140,
                                          ext_base + 32'h080, ext_base + 32'h0c0};
  logic [data_w-1:0] t_len  [n_tests] = '{32'd7, 32'd4, 32'd5, 32'd0};
  logic              t_irq  [n_tests] = '{1'b1, 1'b0, 1'b1, 1'b1};

  logic [data_w-1:0] tcdm_mem [128];
  logic [data_w-1:0] ext_mem  [64];
  logic [data_w-1:0] exp_tcdm [128];
  logic [data_w-1:0] exp_ext  [64];
  logic [31:0]       lfsr_q     = 32'h3bba;
  int unsigned       access_cnt = 0;
  int unsigned       event_cnt  = 0;
  int unsigned       err_cnt    = 0;

  dma_wrap #(
    .TCDM_BASE ( tcdm_base ),
    .TCDM_SIZE ( tcdm_size )
  ) i_dut (
    .clk_i         ( clk         ),
    .reset_i       ( reset       ),
    .cfg_req_i     ( cfg_req     ),
    .cfg_rsp_o     ( cfg_rsp     ),
    .ext_req_o     ( ext_req     ),
    .ext_rsp_i     ( ext_rsp     ),
    .bank_req_o    ( bank_req    ),
    .bank_rvalid_i ( bank_rvalid ),
    .bank_rdata_i  ( bank_rdata  ),
    .term_event_o  ( term_event  ),
    .term_irq_o    ( term_irq    ),
    .busy_o        ( busy        )
  );

  always #50 clk = ~clk;

  // galois lfsr, taps x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [data_w-1:0] rand_word();
    logic [data_w-1:0] w;
    w = '0;
    for (int i = 0; i < data_w; i++) begin
      w      = {w[data_w-2:0], lfsr_q[0]};
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
    end
    return w;
  endfunction

  function automatic logic in_tcdm(input logic [addr_w-1:0] a);
    return (a >= tcdm_base) && (a < tcdm_base + tcdm_size);
  endfunction

  // memory models sample requests mid cycle and answer 1 ns after the next edge
  initial begin
    logic [1:0]             rd_pend;
    logic [1:0][data_w-1:0] rd_word;
    logic                   ext_pend;
    logic [data_w-1:0]      ext_word;
    logic [6:0]             idx;
    bank_rvalid = '0;
    bank_rdata  = '0;
    ext_rsp     = '0;
    for (int i = 0; i < 128; i++) begin
      tcdm_mem[i] = rand_word();
    end
    for (int i = 0; i < 64; i++) begin
      ext_mem[i] = rand_word();
    end
    forever begin
      @(negedge clk);
      rd_pend  = '0;
      rd_word  = '0;
      ext_pend = 1'b0;
      ext_word = '0;
      for (int b = 0; b < 2; b++) begin
        // bank b word a holds TCDM word 2a + b
        idx = {bank_req[b].addr[5:0], 1'(b)};
        if (bank_req[b].req === 1'b1) begin
          access_cnt++;
          if (bank_req[b].wen_n) begin
            rd_pend[b] = 1'b1;
            rd_word[b] = tcdm_mem[idx];
          end else begin
            tcdm_mem[idx] = bank_req[b].wdata;
          end
        end
      end
      if (ext_req.valid === 1'b1) begin
        access_cnt++;
        if (ext_req.we) begin
          ext_mem[ext_req.addr[7:2]] = ext_req.wdata;
        end else begin
          ext_pend = 1'b1;
          ext_word = ext_mem[ext_req.addr[7:2]];
        end
      end
      if (term_event === 1'b1) begin
        event_cnt++;
      end
      @(posedge clk);
      #1;
      bank_rvalid = rd_pend;
      bank_rdata  = rd_word;
      ext_rsp     = '{valid: ext_pend, rdata: ext_word};
    end
  end

  task automatic check_cfg_rsp(input string name, input cfg_rsp_t exp, input cfg_rsp_t act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_word(input string name, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] act);
    if (act !== exp) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s expected %b actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic reg_access(input logic wr, input reg_addr_t addr,
                            input logic [data_w-1:0] wdata, output cfg_rsp_t rsp);
    int n;
    @(posedge clk);
    #1;
    cfg_req = '{valid: 1'b1, write: wr, reg_addr: addr, wdata: wdata};
    @(posedge clk);
    #1;
    cfg_req = '0;
    rsp     = '0;
    n       = 0;
    // the reply is due in the cycle right after the request
    while (n < tmo && !rsp.valid) begin
      @(negedge clk);
      rsp = cfg_rsp;
      n++;
    end
    if (!rsp.valid) begin
      $display("timeout, no register reply for offset %0d", addr);
      err_cnt++;
    end else if (n != 1) begin
      $display("register reply for offset %0d came %0d cycles late", addr, n - 1);
      err_cnt++;
    end
  endtask

  task automatic reg_write(input reg_addr_t addr, input logic [data_w-1:0] wdata);
    cfg_rsp_t rsp;
    reg_access(1'b1, addr, wdata, rsp);
  endtask

  task automatic reg_expect(input string name, input reg_addr_t addr,
                            input logic [data_w-1:0] exp);
    cfg_rsp_t rsp;
    cfg_rsp_t want;
    want = '{valid: 1'b1, rdata: exp};
    reg_access(1'b0, addr, '0, rsp);
    check_cfg_rsp(name, want, rsp);
  endtask

  // destination word i takes source word i in the expected image
  task automatic ref_copy(input logic [addr_w-1:0] src, input logic [addr_w-1:0] dst,
                          input logic [data_w-1:0] len);
    logic [data_w-1:0] v;
    logic [addr_w-1:0] s;
    logic [addr_w-1:0] d;
    for (int unsigned i = 0; i < len; i++) begin
      s = src + (i << 2);
      d = dst + (i << 2);
      v = in_tcdm(s) ? exp_tcdm[s[8:2]] : exp_ext[s[7:2]];
      if (in_tcdm(d)) begin
        exp_tcdm[d[8:2]] = v;
      end else begin
        exp_ext[d[7:2]] = v;
      end
    end
  endtask

  // busy has to stay high until the termination event
  task automatic wait_done(input string name);
    logic seen;
    seen = term_event;
    for (int n = 0; n < tmo && !seen; n++) begin
      check_flag({name, " busy"}, 1'b1, busy);
      @(negedge clk);
      seen = term_event;
    end
    if (!seen) begin
      $display("timeout, transfer %s never signaled completion", name);
      err_cnt++;
    end
  endtask

  task automatic check_memories(input string name);
    for (int i = 0; i < 128; i++) begin
      check_word($sformatf("%s tcdm[%0d]", name, i), exp_tcdm[i], tcdm_mem[i]);
    end
    for (int i = 0; i < 64; i++) begin
      check_word($sformatf("%s ext[%0d]", name, i), exp_ext[i], ext_mem[i]);
    end
  endtask

  task automatic run_test(input int k);
    dma_cmd_u          cmd;
    int unsigned       acc0;
    int unsigned       ev0;
    logic [data_w-1:0] stat;
    reg_write(reg_src, t_src[k]);
    reg_write(reg_dst, t_dst[k]);
    reg_write(reg_len, t_len[k]);
    reg_expect({t_name[k], " src"}, reg_src, t_src[k]);
    reg_expect({t_name[k], " dst"}, reg_dst, t_dst[k]);
    reg_expect({t_name[k], " len"}, reg_len, t_len[k]);
    acc0              = access_cnt;
    ev0               = event_cnt;
    cmd.raw           = '0;
    cmd.fields.start  = 1'b1;
    cmd.fields.irq_en = t_irq[k];
    reg_write(reg_cmd, cmd.raw);
    // descriptor writes while the copy runs must not stick
    if (t_len[k] >= 3) begin
      reg_write(reg_src, 32'hdead_beef);
      reg_write(reg_len, 32'h0000_0001);
    end
    wait_done(t_name[k]);
    ref_copy(t_src[k], t_dst[k], t_len[k]);
    @(negedge clk);
    check_flag({t_name[k], " busy after done"}, 1'b0, busy);
    @(negedge clk);
    check_flag({t_name[k], " single event"}, 1'b1, (event_cnt - ev0) == 1);
    check_word({t_name[k], " access count"}, 2 * t_len[k], access_cnt - acc0);
    check_flag({t_name[k], " irq"}, t_irq[k], term_irq);
    check_memories(t_name[k]);
    stat = {30'b0, t_irq[k], 1'b0};
    reg_expect({t_name[k], " status"}, reg_status, stat);
    if (t_irq[k]) begin
      check_flag({t_name[k], " irq held"}, 1'b1, term_irq);
      reg_write(reg_status, 32'h0000_0002);
      check_flag({t_name[k], " irq cleared"}, 1'b0, term_irq);
    end
    reg_expect({t_name[k], " src kept"}, reg_src, t_src[k]);
    reg_expect({t_name[k], " len kept"}, reg_len, t_len[k]);
  endtask

  task automatic report_test(input string name, input int unsigned errs0,
                             inout int unsigned n_pass);
    if (err_cnt == errs0) begin
      n_pass++;
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, err_cnt - errs0);
    end
  endtask

  initial begin
    int unsigned n_pass;
    int unsigned errs0;
    n_pass  = 0;
    reset   = 1'b1;
    cfg_req = '0;
    repeat (5) @(posedge clk);
    #1;
    reset    = 1'b0;
    exp_tcdm = tcdm_mem;
    exp_ext  = ext_mem;
    errs0    = err_cnt;
    @(negedge clk);
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset event", 1'b0, term_event);
    check_flag("reset irq", 1'b0, term_irq);
    reg_expect("reset status", reg_status, '0);
    reg_expect("reset src", reg_src, '0);
    report_test("reset_values", errs0, n_pass);
    for (int k = 0; k < n_tests; k++) begin
      errs0 = err_cnt;
      run_test(k);
      report_test(t_name[k], errs0, n_pass);
    end
    $display("tests %0d, passed %0d, failed %0d, check errors %0d",
             n_tests + 1, n_pass, n_tests + 1 - n_pass, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tcdm_bank_demux.sv
// TCDM bank demux
// spreads word accesses over two interleaved banks,
// flips write enable to active low and returns the bank's read data
`timescale 1ns/1ps
`default_nettype none

module tcdm_bank_demux (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  dma_pkg::mem_req_t                      req_i,
  output dma_pkg::mem_rsp_t                      rsp_o,
  output dma_pkg::bank_req_t [1:0]               bank_req_o,
  input  logic [1:0]                             bank_rvalid_i,
  input  logic [1:0][dma_pkg::data_w-1:0]        bank_rdata_i
);
  import dma_pkg::*;

  localparam int unsigned n_banks = 2;

  logic bank_sel;
  logic bank_sel_q;

  // word address bit 0 picks the bank
  assign bank_sel = req_i.addr[2];

  for (genvar b = 0; b < n_banks; b++) begin : gen_bank
    always_comb begin
      bank_req_o[b].req   = req_i.valid & (bank_sel == 1'(b));
      bank_req_o[b].wen_n = ~req_i.we;
      bank_req_o[b].addr  = req_i.addr[addr_w-1:3];
      bank_req_o[b].wdata = req_i.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bank_sel_q <= 1'b0;
    end else if (req_i.valid) begin
      bank_sel_q <= bank_sel;
    end
  end

  // reply comes from the bank addressed one cycle earlier
  always_comb begin
    rsp_o.valid = bank_rvalid_i[bank_sel_q];
    rsp_o.rdata = bank_rdata_i[bank_sel_q];
  end

endmodule

`default_nettype wire
